// File: Makefile
TOP = tbSnakeGame

sim:
	verilator --binary --timing --assert -f snakeGame.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: hw/collisionDetector.sv
`timescale 1ns/1ns

module collisionDetector #(
    parameter int boardW    = 16,
    parameter int boardH    = 16,
    parameter int maxLength = 16,
    parameter int numWalls  = 4
) (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               checkEnable,
    input  snakePkg::cellT                     nextHead,
    input  logic [maxLength-1:0][3:0]          segX,
    input  logic [maxLength-1:0][3:0]          segY,
    input  logic [maxLength-1:0]               segValid,
    input  snakePkg::cellT                     apple,
    input  snakePkg::cellT [numWalls-1:0]      walls,
    output logic                               badCollision,
    output logic                               goodCollision
);
    // outermost row and column are the border
    localparam logic [3:0] maxX = 4'(boardW - 1);
    localparam logic [3:0] maxY = 4'(boardH - 1);

    logic borderHit;
    logic wallHit;
    logic selfHit;
    logic appleHit;

    always_comb begin
        // left, right, top, bottom
        borderHit = (nextHead.xy.x == 4'd0) || (nextHead.xy.x >= maxX) ||
                    (nextHead.xy.y == 4'd0) || (nextHead.xy.y >= maxY);

        // host placed walls, byte compare
        wallHit = 1'b0;
        for (int i = 0; i < numWalls; i++) begin
            wallHit |= (walls[i].raw == nextHead.raw);
        end

        // every live segment counts, tail too
        selfHit = 1'b0;
        for (int i = 0; i < maxLength; i++) begin
            selfHit |= segValid[i] && ({segY[i], segX[i]} == nextHead.raw);
        end

        appleHit = (apple.raw == nextHead.raw);
    end

    // flags sampled on the check edge, held between checks
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            badCollision  <= 1'b0;
            goodCollision <= 1'b0;
        end else if (checkEnable) begin
            badCollision  <= borderHit || wallHit || selfHit;
            goodCollision <= appleHit;
        end
    end

endmodule

// File: hw/snakeBody.sv
`timescale 1ns/1ns

module snakeBody #(
    parameter int boardW    = 16,
    parameter int boardH    = 16,
    parameter int maxLength = 16
) (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        bodyInit,
    input  logic                        commit,
    input  logic                        grow,
    input  snakePkg::dirT               dir,
    output snakePkg::cellT              nextHead,
    output snakePkg::cellT              head,
    output logic [maxLength-1:0][3:0]   segX,
    output logic [maxLength-1:0][3:0]   segY,
    output logic [maxLength-1:0]        segValid,
    output logic [4:0]                  length,
    output logic [6:0]                  score
);
    import snakePkg::*;

    // spawn cell at the board center
    localparam logic [3:0] startX = 4'(boardW / 2);
    localparam logic [3:0] startY = 4'(boardH / 2);
    localparam logic [4:0] lenMax = 5'(maxLength);

    // slot 0 is always the head
    assign head.raw = {segY[0], segX[0]};

    // one step in dir, wrapping mod 16 so the border check sees it
    always_comb begin
        nextHead = head;
        case (dir)
            dirRight: nextHead.xy.x = head.xy.x + 4'd1;
            dirUp:    nextHead.xy.y = head.xy.y - 4'd1;
            dirLeft:  nextHead.xy.x = head.xy.x - 4'd1;
            dirDown:  nextHead.xy.y = head.xy.y + 4'd1;
            default:  nextHead = head;
        endcase
    end

    // segment shift register, tail falls off the top slot
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            segX <= '0;
            segY <= '0;
        end else if (bodyInit) begin
            segX[0] <= startX;
            segY[0] <= startY;
        end else if (commit) begin
            segX <= {segX[maxLength-2:0], nextHead.xy.x};
            segY <= {segY[maxLength-2:0], nextHead.xy.y};
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            length <= 5'd0;
            score  <= 7'd0;
        end else if (bodyInit) begin
            length <= 5'd1;
            score  <= 7'd0;
        end else if (commit && grow) begin
            // length stops at the slot count
            if (length < lenMax) begin
                length <= length + 5'd1;
            end
            // score saturates
            if (score != 7'd127) begin
                score <= score + 7'd1;
            end
        end
    end

    // live slots sit below length
    always_comb begin
        for (int i = 0; i < maxLength; i++) begin
            segValid[i] = (5'(i) < length);
        end
    end

endmodule

// File: hw/snakeCtrl.sv
`timescale 1ns/1ns

module snakeCtrl (
    input  logic                clk,
    input  logic                nrst,
    input  logic                startPulse,
    input  logic                tick,
    input  logic                badCollision,
    input  logic                goodCollision,
    output logic                running,
    output logic                checkEnable,
    output logic                bodyInit,
    output logic                commit,
    output logic                grow,
    output snakePkg::gameStateT gameState
);
    import snakePkg::*;

    logic canStart;

    // start only from idle or after a death
    assign canStart = (gameState == stIdle) || (gameState == stDead);

    // timer counts through run and check
    assign running = (gameState == stRun) || (gameState == stCheck);

    // detector samples the next head on the tick edge
    assign checkEnable = (gameState == stRun) && tick;

    // body resets on the same edge the state enters run
    assign bodyInit = canStart && startPulse;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            gameState <= stIdle;
            commit    <= 1'b0;
            grow      <= 1'b0;
        end else begin
            commit <= 1'b0;
            grow   <= 1'b0;
            case (gameState)
                stIdle, stDead: begin
                    if (startPulse) begin
                        gameState <= stRun;
                    end
                end
                stRun: begin
                    if (tick) begin
                        gameState <= stCheck;
                    end
                end
                stCheck: begin
                    // flags are fresh here, one cycle after the sample
                    if (badCollision) begin
                        gameState <= stDead;
                    end else begin
                        // move lands on the following edge
                        commit    <= 1'b1;
                        grow      <= goodCollision;
                        gameState <= stRun;
                    end
                end
                default: gameState <= stIdle;
            endcase
        end
    end

    // a restart never overlaps a move
    assert property (@(posedge clk) disable iff (!nrst) !(commit && bodyInit));

    // growth only rides on a committed move
    assert property (@(posedge clk) disable iff (!nrst) grow |-> commit);

endmodule

// File: hw/snakeGame.sv
`timescale 1ns/1ns

module snakeGame #(
    parameter int boardW     = 16,
    parameter int boardH     = 16,
    parameter int maxLength  = 16,
    parameter int numWalls   = 4,
    parameter int tickPeriod = 8
) (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [2:0]                   adr,
    input  logic [snakePkg::wbDataW-1:0] datI,
    output logic [snakePkg::wbDataW-1:0] datO,
    output logic                         ack,
    output logic                         frameStrobe
);
    import snakePkg::*;

    // host registers
    dirT                      dir;
    logic                     startPulse;
    cellT                     apple;
    cellT [numWalls-1:0]      walls;

    // sequencer and timer
    gameStateT                gameState;
    logic                     running;
    logic                     tick;
    logic                     checkEnable;
    logic                     bodyInit;
    logic                     grow;

    // body and detector
    cellT                     nextHead;
    cellT                     head;
    logic [maxLength-1:0][3:0] segX;
    logic [maxLength-1:0][3:0] segY;
    logic [maxLength-1:0]     segValid;
    logic [4:0]               length;
    logic [6:0]               score;
    logic                     badCollision;
    logic                     goodCollision;

    wbRegs #(.numWalls(numWalls)) i_regs (
        .clk, .nrst, .cyc, .stb, .we, .adr, .datI, .datO, .ack,
        .dir, .startPulse, .apple, .walls, .gameState, .head, .length, .score
    );

    // commit doubles as the display frame strobe
    snakeCtrl i_ctrl (
        .clk, .nrst, .startPulse, .tick, .badCollision, .goodCollision,
        .running, .checkEnable, .bodyInit, .commit(frameStrobe), .grow, .gameState
    );

    stepTimer #(.tickPeriod(tickPeriod)) i_timer (
        .clk, .nrst, .running, .tick
    );

    snakeBody #(.boardW(boardW), .boardH(boardH), .maxLength(maxLength)) i_body (
        .clk, .nrst, .bodyInit, .commit(frameStrobe), .grow, .dir,
        .nextHead, .head, .segX, .segY, .segValid, .length, .score
    );

    collisionDetector #(
        .boardW(boardW), .boardH(boardH), .maxLength(maxLength), .numWalls(numWalls)
    ) i_coll (
        .clk, .nrst, .checkEnable, .nextHead, .segX, .segY, .segValid,
        .apple, .walls, .badCollision, .goodCollision
    );

endmodule

// File: hw/snakePkg.sv
package snakePkg;

    // bus data width for the register block
    localparam int wbDataW = 16;

    // one board cell, compared as a byte or split into row and column
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            // row, up is smaller
            logic [3:0] y;
            // column
            logic [3:0] x;
        } xy;
    } cellT;

    // game sequencer states, also reported in the status word
    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stCheck,
        stDead
    } gameStateT;

    // move direction, up decrements y
    typedef enum logic [1:0] {
        dirRight,
        dirUp,
        dirLeft,
        dirDown
    } dirT;

    // register word addresses
    localparam logic [2:0] regCtrl  = 3'd0;
    localparam logic [2:0] regApple = 3'd1;
    localparam logic [2:0] regWall0 = 3'd2;
    localparam logic [2:0] regWall1 = 3'd3;
    localparam logic [2:0] regWall2 = 3'd4;
    localparam logic [2:0] regWall3 = 3'd5;
    localparam logic [2:0] regHead  = 3'd6;

endpackage

// File: hw/stepTimer.sv
`timescale 1ns/1ns

module stepTimer #(
    parameter int tickPeriod = 8
) (
    input  logic clk,
    input  logic nrst,
    input  logic running,
    output logic tick
);
    localparam int cntW = (tickPeriod > 1) ? $clog2(tickPeriod) : 1;
    localparam logic [cntW-1:0] lastCount = cntW'(tickPeriod - 1);

    logic [cntW-1:0] count;

    // move period counter, parked at 0 while no game runs
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (!running) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == lastCount) begin
            // wrap gives the move pulse
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

    // the check cycle must finish before the next tick lands
    if (tickPeriod < 3) begin : gPeriodCheck
        $error("stepTimer: tickPeriod below 3 overlaps two moves");
    end

    // ticks stay separated by a full period
    assert property (@(posedge clk) disable iff (!nrst) tick |=> !tick);

endmodule

// File: hw/wbRegs.sv
`timescale 1ns/1ns

module wbRegs #(
    parameter int numWalls = 4
) (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               cyc,
    input  logic                               stb,
    input  logic                               we,
    input  logic [2:0]                         adr,
    input  logic [snakePkg::wbDataW-1:0]       datI,
    output logic [snakePkg::wbDataW-1:0]       datO,
    output logic                               ack,
    output snakePkg::dirT                      dir,
    output logic                               startPulse,
    output snakePkg::cellT                     apple,
    output snakePkg::cellT [numWalls-1:0]      walls,
    input  snakePkg::gameStateT                gameState,
    input  snakePkg::cellT                     head,
    input  logic [4:0]                         length,
    input  logic [6:0]                         score
);
    import snakePkg::*;

    logic               access;
    logic [wbDataW-1:0] rdData;

    // new cycle seen, ack not yet given
    assign access = cyc && stb && !ack;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ack        <= 1'b0;
            startPulse <= 1'b0;
            dir        <= dirRight;
            apple      <= '0;
            // cell 0 sits on the border, harmless
            walls      <= '0;
        end else begin
            ack        <= access;
            startPulse <= access && we && (adr == regCtrl) && datI[15];
            if (access && we) begin
                if (adr == regCtrl) begin
                    dir <= dirT'(datI[1:0]);
                end
                if (adr == regApple) begin
                    apple.raw <= datI[7:0];
                end
                for (int i = 0; i < numWalls; i++) begin
                    if (adr == 3'(regWall0 + i)) begin
                        walls[i].raw <= datI[7:0];
                    end
                end
            end
        end
    end

    // status and cell read mux
    always_comb begin
        rdData = '0;
        if (adr == regCtrl) begin
            rdData = {score, length, gameState, dir};
        end else if (adr == regApple) begin
            rdData[7:0] = apple.raw;
        end else if (adr == regHead) begin
            rdData[7:0] = head.raw;
        end
        for (int i = 0; i < numWalls; i++) begin
            if (adr == 3'(regWall0 + i)) begin
                rdData[7:0] = walls[i].raw;
            end
        end
    end

    // read data valid with ack
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            datO <= '0;
        end else if (access) begin
            datO <= rdData;
        end
    end

    // every ack answers a request one cycle earlier
    assert property (@(posedge clk) disable iff (!nrst) ack |-> $past(cyc && stb));

endmodule

// File: snakeGame.f
hw/snakePkg.sv
hw/stepTimer.sv
hw/snakeCtrl.sv
hw/snakeBody.sv
hw/collisionDetector.sv
hw/wbRegs.sv
hw/snakeGame.sv
verif/tbSnakeGame.sv

// File: verif/tbSnakeGame.sv
`timescale 1ns/1ns

module tbSnakeGame;
    import snakePkg::*;

    localparam int tickPeriod = 8;
    localparam int numGames = 24;
    localparam int movesPerGame = 40;
    localparam int clkPeriod = 100;
    localparam int watchLimit = numGames * movesPerGame * tickPeriod * 4 + 1000;

    logic               clk;
    logic               nrst;
    logic               cyc;
    logic               stb;
    logic               we;
    logic [2:0]         adr;
    logic [wbDataW-1:0] datI;
    logic [wbDataW-1:0] datO;
    logic               ack;
    logic               frameStrobe;

    // reference model of the board
    cellT segQ[$];
    cellT mApple;
    cellT mWalls[4];
    dirT  mDir;
    int   mLen;
    int   mScore;

    int valueErrors;
    int otherErrors;

    snakeGame #(.tickPeriod(tickPeriod)) i_dut (
        .clk, .nrst, .cyc, .stb, .we, .adr, .datI, .datO, .ack, .frameStrobe
    );

    always #50 clk = ~clk;

    task automatic checkCell(input string name, input cellT got, input cellT exp);
        if (got.raw !== exp.raw) begin
            $display("[ERROR] %0t ns %s: dut=%h expected=%h", $time, name, got.raw, exp.raw);
            valueErrors++;
        end
    endtask

    task automatic checkStatus(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: dut=%h expected=%h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t ns %s: dut=%0d expected=%0d", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    // one classic cycle, ack sampled mid-period
    task automatic busAccess(input logic wr, input logic [2:0] a,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(posedge clk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= wr;
        adr  <= a;
        datI <= wdata;
        forever begin
            @(negedge clk);
            if (ack) begin
                rdata = datO;
                break;
            end
            waited++;
            if (waited > 16) begin
                $display("bus access to address %0d was never acknowledged", a);
                otherErrors++;
                break;
            end
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic busWrite(input logic [2:0] a, input logic [15:0] wdata);
        logic [15:0] unused;
        busAccess(1'b1, a, wdata, unused);
    endtask

    task automatic busRead(input logic [2:0] a, output logic [15:0] rdata);
        busAccess(1'b0, a, 16'h0000, rdata);
    endtask

    // wraps in 4 bits like the board coordinates
    function automatic cellT stepCell(input cellT c, input dirT d);
        cellT n;
        n = c;
        case (d)
            dirRight: n.xy.x = c.xy.x + 4'd1;
            dirUp:    n.xy.y = c.xy.y - 4'd1;
            dirLeft:  n.xy.x = c.xy.x - 4'd1;
            default:  n.xy.y = c.xy.y + 4'd1;
        endcase
        return n;
    endfunction

    function automatic bit isDeadly(input cellT n);
        bit hit;
        hit = (n.xy.x == 4'd0) || (n.xy.x == 4'd15) || (n.xy.y == 4'd0) || (n.xy.y == 4'd15);
        foreach (mWalls[i]) hit |= (mWalls[i].raw == n.raw);
        foreach (segQ[i]) hit |= (segQ[i].raw == n.raw);
        return hit;
    endfunction

    function automatic logic [15:0] statusWord(input gameStateT st);
        return {7'(mScore), 5'(mLen), st, mDir};
    endfunction

    task automatic waitStrobe(input int limit, output bit seen, output time at);
        seen = 0;
        at = 0;
        repeat (limit) begin
            @(negedge clk);
            if (frameStrobe) begin
                seen = 1;
                at = $time;
                break;
            end
        end
    endtask

    // host action between moves, at most one write
    task automatic hostAction(inout bit moveApple);
        int r;
        int idx;
        dirT nd;
        r = $urandom_range(0, 15);
        if (moveApple) begin
            // eaten apple parked on the border corner
            mApple.raw = 8'h00;
            busWrite(regApple, 16'h0000);
            moveApple = 0;
        end else if (r == 0) begin
            idx = $urandom_range(0, 3);
            mWalls[idx] = stepCell(segQ[0], mDir);
            busWrite(3'(regWall0 + idx), {8'h00, mWalls[idx].raw});
        end else if (r <= 2 && mLen >= 2) begin
            // reversal runs into the neck
            mDir = dirT'(2'(mDir + 2'd2));
            busWrite(regCtrl, {14'h0, mDir});
        end else if (r <= 6) begin
            mApple = stepCell(segQ[0], mDir);
            busWrite(regApple, {8'h00, mApple.raw});
        end else begin
            nd = dirT'(2'($urandom_range(0, 3)));
            if (mLen >= 2 && nd == dirT'(2'(mDir + 2'd2))) nd = mDir;
            mDir = nd;
            busWrite(regCtrl, {14'h0, mDir});
        end
    endtask

    task automatic playGame();
        logic [15:0] d;
        cellT c;
        cellT n;
        bit skipWrite;
        bit moveApple;
        bit seen;
        bit good;
        time at;
        time last;
        int m;
        mApple.raw = 8'h00;
        busWrite(regApple, 16'h0000);
        for (int i = 0; i < 4; i++) begin
            mWalls[i].raw = 8'h00;
            busWrite(3'(regWall0 + i), 16'h0000);
        end
        mDir = dirT'(2'($urandom_range(0, 3)));
        busWrite(regCtrl, {1'b1, 13'h0, mDir});
        c.raw = 8'h88;
        segQ = {c};
        mLen = 1;
        mScore = 0;
        busRead(regCtrl, d);
        checkStatus("status after start", d, statusWord(stRun));
        busRead(regHead, d);
        c.raw = d[7:0];
        checkCell("head after start", c, segQ[0]);
        skipWrite = 1;
        moveApple = 0;
        last = 0;
        m = 0;
        // past the move budget the host stays quiet and the snake runs into the border
        forever begin
            if (!skipWrite && m < movesPerGame) hostAction(moveApple);
            skipWrite = 0;
            n = stepCell(segQ[0], mDir);
            if (isDeadly(n)) begin
                waitStrobe(2 * tickPeriod, seen, at);
                if (seen) begin
                    $display("frame strobe came after a deadly move at %0t ns", at);
                    otherErrors++;
                end
                busRead(regCtrl, d);
                checkStatus("status after death", d, statusWord(stDead));
                busRead(regHead, d);
                c.raw = d[7:0];
                checkCell("head after death", c, segQ[0]);
                return;
            end
            waitStrobe(tickPeriod + 4, seen, at);
            if (!seen) begin
                $display("no frame strobe for a legal move at %0t ns", $time);
                otherErrors++;
                return;
            end
            if (m > 0) checkCount("strobe interval", int'((at - last) / clkPeriod), tickPeriod);
            last = at;
            good = (n.raw == mApple.raw);
            segQ.push_front(n);
            if (good && mLen < 16) mLen++;
            if (good && mScore < 127) mScore++;
            while (segQ.size() > mLen) void'(segQ.pop_back());
            busRead(regHead, d);
            c.raw = d[7:0];
            checkCell("head", c, segQ[0]);
            if (good) begin
                busRead(regCtrl, d);
                checkStatus("status after apple", d, statusWord(stRun));
                skipWrite = 1;
                moveApple = 1;
            end
            m++;
        end
    endtask

    initial begin
        logic [15:0] d;
        logic [15:0] w;
        logic [2:0] a;
        clk = 1'b0;
        nrst = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = 3'd0;
        datI = 16'h0000;
        valueErrors = 0;
        otherErrors = 0;
        void'($urandom(32'hc6c4_080a));
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        // idle, right, empty
        busRead(regCtrl, d);
        checkStatus("status after reset", d, 16'h0000);
        for (int i = 0; i < 12; i++) begin
            a = 3'($urandom_range(1, 5));
            w = {8'h00, 8'($urandom_range(0, 255))};
            busWrite(a, w);
            busRead(a, d);
            checkStatus("register readback", d, w);
        end
        for (int g = 0; g < numGames; g++) playGame();
        $display("errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // bound scales with games and move length
    initial begin
        repeat (watchLimit) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
